// ==== Bender.yml ====
package:
  name: lsu_path

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_pkg.sv
      - dtcm_pkg.sv
      - lsu_agu.sv
      - lsu_pipe_stage.sv
      - lsu_ctrl.sv
      - dtcm_ram.sv
      - lsu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - lsu_props.sv
      - tb_lsu_top.sv

// ==== dtcm_pkg.sv ====
//====================
// memory-side types of the load/store path
// DTCM address, request, command, response and tracking entry
//====================

`default_nettype none

`include "lsu_consts.svh"

package dtcm_pkg;

    // byte address inside the DTCM
    typedef logic [`LSU_DTCM_AW-1:0] dtcm_addr_t;

    // request as it arrives from the issue stage
    typedef struct packed {
        logic              read;
        logic              usign;
        rv_pkg::lsu_size_e size;
        rv_pkg::xlen_t     base;
        rv_pkg::xlen_t     offset;
        rv_pkg::xlen_t     wdata;
        rv_pkg::itag_t     itag;
    } lsu_req_t;

    // AGU output, address formed and store data on its lanes
    typedef struct packed {
        logic              read;
        logic              usign;
        rv_pkg::lsu_size_e size;
        dtcm_addr_t        addr;
        rv_pkg::xlen_t     wdata;
        rv_pkg::bmask_t    wmask;
        rv_pkg::itag_t     itag;
    } agu_cmd_t;

    // command seen by the DTCM
    typedef struct packed {
        logic           read;
        dtcm_addr_t     addr;
        rv_pkg::xlen_t  wdata;
        rv_pkg::bmask_t wmask;
    } dtcm_cmd_t;

    // write-back response
    typedef struct packed {
        rv_pkg::itag_t itag;
        logic          read;
        rv_pkg::xlen_t data;
    } lsu_rsp_t;

    // what the control unit remembers about the outstanding access
    typedef struct packed {
        rv_pkg::itag_t     itag;
        logic              read;
        logic              usign;
        rv_pkg::lsu_size_e size;
        logic [1:0]        byte_ofs;
    } lsu_track_t;

endpackage

`default_nettype wire

// ==== dtcm_ram.sv ====
//====================
// tightly coupled data memory
// byte-masked writes, one cycle registered read
//====================

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module dtcm_ram (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // command side, always ready
    input  logic                cmd_valid_i,
    input  dtcm_pkg::dtcm_cmd_t cmd_i,

    // response side
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output rv_pkg::xlen_t       rdata_o
);

    localparam int unsigned WIDX_W = $clog2(`LSU_DTCM_DEPTH);

    rv_pkg::xlen_t     mem_q [`LSU_DTCM_DEPTH];
    rv_pkg::xlen_t     rdata_q;
    logic              rsp_valid_q;
    logic [WIDX_W-1:0] widx;

    // word index, byte offset bits dropped
    assign widx = cmd_i.addr[WIDX_W+1:2];

    always_ff @(posedge clk_i) begin
        for (int b = 0; b < $bits(rv_pkg::bmask_t); b++) begin
            if (cmd_valid_i && !cmd_i.read && cmd_i.wmask[b]) begin
                mem_q[widx][8*b +: 8] <= cmd_i.wdata[8*b +: 8];
            end
        end
    end

    // held until the next accepted load
    always_ff @(posedge clk_i) begin
        if (cmd_valid_i && cmd_i.read) begin
            rdata_q <= mem_q[widx];
        end
    end

    // every command, stores too, gets one response
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (cmd_valid_i) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rdata_o     = rdata_q;

endmodule

`default_nettype wire

// ==== lsu_agu.sv ====
//====================
// address generation unit
// byte address, store lane placement and write mask
//====================

`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
    // request from the issue stage
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  dtcm_pkg::lsu_req_t req_i,

    // command towards the control unit
    output logic               cmd_valid_o,
    input  logic               cmd_ready_i,
    output dtcm_pkg::agu_cmd_t cmd_o
);

    rv_pkg::xlen_t        addr_sum;
    dtcm_pkg::dtcm_addr_t addr;
    logic [1:0]           byte_ofs;
    rv_pkg::bmask_t       size_mask;

    // no state here, the handshake passes straight through
    assign cmd_valid_o = req_valid_i;
    assign req_ready_o = cmd_ready_i;

    // full add, then keep the bits the DTCM decodes
    assign addr_sum = req_i.base + req_i.offset;
    assign addr     = dtcm_pkg::dtcm_addr_t'(addr_sum);
    assign byte_ofs = addr[1:0];

    // lanes covered by the access before the offset is applied
    always_comb begin
        case (req_i.size)
            rv_pkg::size_byte: size_mask = 4'b0001;
            rv_pkg::size_half: size_mask = 4'b0011;
            rv_pkg::size_word: size_mask = 4'b1111;
            default:           size_mask = 4'b0000;
        endcase
    end

    always_comb begin
        cmd_o.read  = req_i.read;
        cmd_o.usign = req_i.usign;
        cmd_o.size  = req_i.size;
        cmd_o.addr  = addr;
        cmd_o.itag  = req_i.itag;
        // store data moves up to the addressed lane
        cmd_o.wdata = req_i.wdata << {byte_ofs, 3'b000};
        // loads never write
        cmd_o.wmask = req_i.read ? '0 : (size_mask << byte_ofs);
    end

endmodule

`default_nettype wire

// ==== lsu_consts.svh ====
//====================
// load/store path constants
// data width, tag width and DTCM geometry
//====================

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// width of an integer register and of a DTCM word
`define LSU_XLEN 32

// instruction tag carried from issue to write-back
`define LSU_ITAG_WIDTH 3

// DTCM byte address width, 4 KiB of data memory
`define LSU_DTCM_AW 12

// number of words in the DTCM
// must match LSU_DTCM_AW with the two byte offset bits removed
`define LSU_DTCM_DEPTH 1024

`endif

// ==== lsu_ctrl.sv ====
//====================
// load/store control unit
// issues DTCM commands, tracks the outstanding access
// and formats load data for write-back
//====================

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_ctrl (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // command from the AGU
    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,
    input  dtcm_pkg::agu_cmd_t  cmd_i,

    // DTCM command and response
    output logic                dtcm_valid_o,
    input  logic                dtcm_ready_i,
    output dtcm_pkg::dtcm_cmd_t dtcm_cmd_o,
    input  logic                dtcm_rsp_valid_i,
    output logic                dtcm_rsp_ready_o,
    input  rv_pkg::xlen_t       dtcm_rdata_i,

    // write-back response
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output dtcm_pkg::lsu_rsp_t  rsp_o
);

    dtcm_pkg::lsu_track_t trk_in;
    dtcm_pkg::lsu_track_t trk;
    logic                 trk_valid;
    logic                 trk_ready;
    logic                 trk_pop;
    logic                 ld_rsp;
    rv_pkg::xlen_t        rdata_sh;
    rv_pkg::xlen_t        ld_data;

    //====================
    // command issue
    //====================

    // only one access in flight, so a command waits until the stage has room
    assign dtcm_valid_o = cmd_valid_i & trk_ready;
    assign cmd_ready_o  = dtcm_ready_i & trk_ready;

    assign dtcm_cmd_o.read  = cmd_i.read;
    assign dtcm_cmd_o.addr  = cmd_i.addr;
    assign dtcm_cmd_o.wdata = cmd_i.wdata;
    assign dtcm_cmd_o.wmask = cmd_i.wmask;

    assign trk_in.itag     = cmd_i.itag;
    assign trk_in.read     = cmd_i.read;
    assign trk_in.usign    = cmd_i.usign;
    assign trk_in.size     = cmd_i.size;
    assign trk_in.byte_ofs = cmd_i.addr[1:0];

    // entry written on the DTCM handshake, freed on the write-back handshake
    assign trk_pop = dtcm_rsp_valid_i & rsp_ready_i;

    lsu_pipe_stage #(
        .DW($bits(dtcm_pkg::lsu_track_t))
    ) u_trk_stage (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .i_valid_i (cmd_valid_i & dtcm_ready_i),
        .i_ready_o (trk_ready),
        .i_data_i  (trk_in),
        .o_valid_o (trk_valid),
        .o_ready_i (trk_pop),
        .o_data_o  (trk)
    );

    //====================
    // response formatting
    //====================

    assign ld_rsp   = trk_valid & trk.read;
    assign rdata_sh = dtcm_rdata_i >> {trk.byte_ofs, 3'b000};

    always_comb begin
        case (trk.size)
            rv_pkg::size_byte: begin
                ld_data = trk.usign ? {{(`LSU_XLEN-8){1'b0}}, rdata_sh[7:0]}
                                    : {{(`LSU_XLEN-8){rdata_sh[7]}}, rdata_sh[7:0]};
            end
            rv_pkg::size_half: begin
                ld_data = trk.usign ? {{(`LSU_XLEN-16){1'b0}}, rdata_sh[15:0]}
                                    : {{(`LSU_XLEN-16){rdata_sh[15]}}, rdata_sh[15:0]};
            end
            default: ld_data = rdata_sh;
        endcase
    end

    assign dtcm_rsp_ready_o = rsp_ready_i;
    assign rsp_valid_o      = dtcm_rsp_valid_i;

    assign rsp_o.itag = trk.itag;
    assign rsp_o.read = trk.read;
    // stores write back zero
    assign rsp_o.data = ld_rsp ? ld_data : '0;

endmodule

`default_nettype wire

// ==== lsu_pipe_stage.sv ====
//====================
// one-entry valid/ready pipeline register
//====================

`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_stage #(
    parameter int unsigned DW = 8
) (
    input  logic          clk_i,
    input  logic          rst_n_i,

    input  logic          i_valid_i,
    output logic          i_ready_o,
    input  logic [DW-1:0] i_data_i,

    output logic          o_valid_o,
    input  logic          o_ready_i,
    output logic [DW-1:0] o_data_o
);

    logic          full_q;
    logic [DW-1:0] data_q;
    logic          push;
    logic          pop;

    assign pop       = full_q & o_ready_i;
    // a full stage still takes a new entry when it drains in the same cycle
    assign i_ready_o = ~full_q | o_ready_i;
    assign push      = i_valid_i & i_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (push) begin
            full_q <= 1'b1;
        end else if (pop) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            data_q <= i_data_i;
        end
    end

    assign o_valid_o = full_q;
    assign o_data_o  = data_q;

endmodule

`default_nettype wire

// ==== lsu_props.sv ====
//====================
// concurrent assertions on the load/store control unit
// response hold, single outstanding access, alignment
//====================

`timescale 1ns/1ps
`default_nettype none

module lsu_props (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 dtcm_valid_i,
    input logic                 rsp_valid_i,
    input logic                 rsp_ready_i,
    input dtcm_pkg::lsu_rsp_t   rsp_i,
    input logic                 trk_valid_i,
    input logic                 trk_pop_i,
    input dtcm_pkg::lsu_track_t trk_i
);

    // failures seen so far, read by the testbench at the end of the run
    int unsigned fail_cnt = 0;

    // a stalled write-back keeps valid and payload
    rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
    else begin
        fail_cnt++;
        $error("write-back response changed while stalled");
    end

    // one access in flight at most
    // a DTCM response that is not drained blocks the next command
    one_outstanding: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i && !trk_pop_i |-> !dtcm_valid_i)
    else begin
        fail_cnt++;
        $error("DTCM command issued while the previous access is still pending");
    end

    // halfwords on even bytes, words on word boundaries
    natural_align: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        trk_valid_i |->
            (trk_i.size != rv_pkg::size_half || !trk_i.byte_ofs[0]) &&
            (trk_i.size != rv_pkg::size_word || trk_i.byte_ofs == 2'b00))
    else begin
        fail_cnt++;
        $error("misaligned access accepted");
    end

endmodule

bind lsu_ctrl lsu_props u_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .dtcm_valid_i (dtcm_valid_o),
    .rsp_valid_i  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_i        (rsp_o),
    .trk_valid_i  (trk_valid),
    .trk_pop_i    (trk_pop),
    .trk_i        (trk)
);

`default_nettype wire

// ==== lsu_top.sv ====
//====================
// load/store path top level
// AGU, control unit and DTCM
//====================

`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // load/store request
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  dtcm_pkg::lsu_req_t req_i,

    // write-back response
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output dtcm_pkg::lsu_rsp_t rsp_o
);

    logic                agu_valid;
    logic                agu_ready;
    dtcm_pkg::agu_cmd_t  agu_cmd;
    logic                dtcm_valid;
    dtcm_pkg::dtcm_cmd_t dtcm_cmd;
    logic                dtcm_rsp_valid;
    logic                dtcm_rsp_ready;
    rv_pkg::xlen_t       dtcm_rdata;

    lsu_agu u_agu (
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .cmd_valid_o (agu_valid),
        .cmd_ready_i (agu_ready),
        .cmd_o       (agu_cmd)
    );

    // the DTCM never stalls a command
    lsu_ctrl u_ctrl (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .cmd_valid_i      (agu_valid),
        .cmd_ready_o      (agu_ready),
        .cmd_i            (agu_cmd),
        .dtcm_valid_o     (dtcm_valid),
        .dtcm_ready_i     (1'b1),
        .dtcm_cmd_o       (dtcm_cmd),
        .dtcm_rsp_valid_i (dtcm_rsp_valid),
        .dtcm_rsp_ready_o (dtcm_rsp_ready),
        .dtcm_rdata_i     (dtcm_rdata),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_ready_i      (rsp_ready_i),
        .rsp_o            (rsp_o)
    );

    dtcm_ram u_dtcm (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (dtcm_valid),
        .cmd_i       (dtcm_cmd),
        .rsp_valid_o (dtcm_rsp_valid),
        .rsp_ready_i (dtcm_rsp_ready),
        .rdata_o     (dtcm_rdata)
    );

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
//====================
// ISA-level types of the load/store path
// data word, tag, byte mask and access size
//====================

`default_nettype none

`include "lsu_consts.svh"

package rv_pkg;

    // one integer register or memory word
    typedef logic [`LSU_XLEN-1:0] xlen_t;

    // instruction tag returned with the write-back
    typedef logic [`LSU_ITAG_WIDTH-1:0] itag_t;

    // one write enable per byte lane of a word
    typedef logic [`LSU_XLEN/8-1:0] bmask_t;

    // access size, taken from funct3[1:0] of the load/store
    // usign (funct3[2]) travels separately
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } lsu_size_e;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+.
rv_pkg.sv
dtcm_pkg.sv
lsu_agu.sv
lsu_pipe_stage.sv
lsu_ctrl.sv
dtcm_ram.sv
lsu_top.sv
lsu_props.sv
tb_lsu_top.sv

// ==== tb_lsu_top.sv ====
//====================
// testbench for the load/store path
// clock, reset, stimulus, byte memory model,
// reference function and compare process
//====================

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module tb_lsu_top;

    localparam int TIMEOUT = 200;

    logic               clk;
    logic               rst_n;
    logic               req_valid;
    logic               req_ready;
    dtcm_pkg::lsu_req_t req;
    logic               rsp_valid;
    logic               rsp_ready;
    dtcm_pkg::lsu_rsp_t rsp;

    logic [7:0]         mem_model [1 << `LSU_DTCM_AW];
    dtcm_pkg::lsu_rsp_t exp_q [$];
    int                 acc_q [$];
    int unsigned        lcg_state = 30;
    rv_pkg::itag_t      next_tag = '0;
    int                 cycle = 0;
    int                 err_count = 0;
    int                 check_count = 0;
    int                 err_mark;
    int                 start_cycle;
    logic               start_seen = 1'b0;
    logic               stall_en = 1'b0;
    int                 stretch = 0;
    rv_pkg::xlen_t      val;
    dtcm_pkg::dtcm_addr_t wa;
    int                 t0;

    lsu_top u_dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_ready_i (rsp_ready),
        .rsp_o       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    //====================
    // helpers
    //====================

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int size_bytes(input rv_pkg::lsu_size_e size);
        case (size)
            rv_pkg::size_byte: return 1;
            rv_pkg::size_half: return 2;
            default:           return 4;
        endcase
    endfunction

    // expected write-back, built byte by byte from the model
    function automatic dtcm_pkg::lsu_rsp_t ref_rsp(input dtcm_pkg::lsu_req_t r);
        dtcm_pkg::lsu_rsp_t   e;
        dtcm_pkg::dtcm_addr_t a;
        rv_pkg::xlen_t        v;
        int                   n;
        a = dtcm_pkg::dtcm_addr_t'(r.base + r.offset);
        n = size_bytes(r.size);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = mem_model[a + i];
        end
        if (!r.usign) begin
            for (int i = 8 * n; i < `LSU_XLEN; i++) v[i] = v[8*n-1];
        end
        e.itag = r.itag;
        e.read = r.read;
        e.data = r.read ? v : '0;
        return e;
    endfunction

    function automatic int total_errors();
        return err_count + u_dut.u_ctrl.u_props.fail_cnt;
    endfunction

    task automatic check_data(input string name, input rv_pkg::xlen_t exp,
                              input rv_pkg::xlen_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Fail %s: expected 0x%h, actual 0x%h", name, exp, act);
        end
    endtask

    task automatic check_tag(input string name, input rv_pkg::itag_t exp,
                             input rv_pkg::itag_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Fail %s: expected 0x%h, actual 0x%h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("Fail %s: expected 0x%h, actual 0x%h", name, exp, act);
        end
    endtask

    task automatic report_and_finish();
        $display("checks: %0d, errors: %0d", check_count, total_errors());
        if (total_errors() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        err_count++;
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        report_and_finish();
    endtask

    // called 2 ns after a rising edge, returns 2 ns after the accepting edge
    task automatic access(input logic read, input logic usign, input rv_pkg::lsu_size_e size,
                          input dtcm_pkg::dtcm_addr_t addr, input rv_pkg::xlen_t wdata);
        int waited;
        req.read   = read;
        req.usign  = usign;
        req.size   = size;
        req.wdata  = wdata;
        req.base   = lcg_next();
        // high bits above the DTCM range must be dropped by the AGU
        req.offset = rv_pkg::xlen_t'(addr) + (lcg_next() << 12) - req.base;
        req.itag   = next_tag;
        next_tag   = next_tag + 1'b1;
        req_valid  = 1'b1;
        waited     = 0;
        @(negedge clk);
        while (!req_ready) begin
            waited++;
            if (waited >= TIMEOUT) abort_on_timeout("request acceptance");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited >= TIMEOUT) abort_on_timeout("response drain");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, total_errors() - err_mark);
        err_mark = total_errors();
    endtask

    //====================
    // response ready, random stretches while stalling
    //====================

    // next level chosen mid-cycle, driven 2 ns after the following edge
    always begin : ready_drive
        logic nxt;
        @(negedge clk);
        nxt = 1'b1;
        if (stall_en) begin
            nxt = rsp_ready;
            if (stretch == 0) begin
                stretch = 1 + lcg_next() % 6;
                nxt     = ~rsp_ready;
            end
            stretch--;
        end
        @(posedge clk);
        #2;
        rsp_ready = nxt;
    end

    //====================
    // compare process, sampled mid-cycle
    //====================

    always @(negedge clk) begin : compare
        dtcm_pkg::lsu_rsp_t   e;
        int                   acc;
        dtcm_pkg::dtcm_addr_t st_addr;
        if (rst_n) begin
            if (rsp_valid && !start_seen) begin
                start_cycle = cycle;
                start_seen  = 1'b1;
            end
            if (rsp_valid && !rsp_ready && req_ready) begin
                err_count++;
                $display("request side stayed ready while the response was stalled");
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("response arrived with no request pending");
                end else begin
                    e   = exp_q.pop_front();
                    acc = acc_q.pop_front();
                    check_tag("rsp_o.itag", e.itag, rsp.itag);
                    check_flag("rsp_o.read", e.read, rsp.read);
                    check_data("rsp_o.data", e.data, rsp.data);
                    if (start_cycle != acc + 1) begin
                        err_count++;
                        $display("response did not appear one cycle after its request");
                    end
                end
                start_seen = 1'b0;
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(ref_rsp(req));
                acc_q.push_back(cycle);
                if (!req.read) begin
                    st_addr = dtcm_pkg::dtcm_addr_t'(req.base + req.offset);
                    for (int i = 0; i < size_bytes(req.size); i++) begin
                        mem_model[st_addr + i] = req.wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    //====================
    // tests
    //====================

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        err_mark  = 0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        for (int k = 0; k < 6; k++) begin
            val = lcg_next();
            access(1'b0, 1'b0, rv_pkg::size_word, 12'h040 + 4 * k, val);
            access(1'b1, 1'b0, rv_pkg::size_word, 12'h040 + 4 * k, '0);
        end
        wait_idle();
        end_test("1 word store/load");

        for (int o = 0; o < 4; o++) begin
            access(1'b0, 1'b0, rv_pkg::size_word, 12'h200, lcg_next());
            access(1'b0, 1'b0, rv_pkg::size_byte, 12'h200 + o, lcg_next());
            access(1'b1, 1'b0, rv_pkg::size_word, 12'h200, '0);
        end
        for (int o = 0; o < 4; o += 2) begin
            access(1'b0, 1'b0, rv_pkg::size_word, 12'h204, lcg_next());
            access(1'b0, 1'b0, rv_pkg::size_half, 12'h204 + o, lcg_next());
            access(1'b1, 1'b0, rv_pkg::size_word, 12'h204, '0);
        end
        wait_idle();
        end_test("2 byte/half lane stores");

        for (int k = 0; k < 3; k++) begin
            val = (k == 0) ? 32'hf08a_c381 : (k == 1) ? 32'h7f01_7f60 : lcg_next();
            access(1'b0, 1'b0, rv_pkg::size_word, 12'h280, val);
            for (int o = 0; o < 4; o++) begin
                access(1'b1, 1'b0, rv_pkg::size_byte, 12'h280 + o, '0);
                access(1'b1, 1'b1, rv_pkg::size_byte, 12'h280 + o, '0);
            end
            for (int o = 0; o < 4; o += 2) begin
                access(1'b1, 1'b0, rv_pkg::size_half, 12'h280 + o, '0);
                access(1'b1, 1'b1, rv_pkg::size_half, 12'h280 + o, '0);
            end
        end
        wait_idle();
        end_test("3 load extension");

        for (int k = 0; k < 8; k++) begin
            access(1'b0, 1'b0, rv_pkg::lsu_size_e'(k % 3), 12'h2c0 + 4 * k, lcg_next());
        end
        wait_idle();
        end_test("4 store responses");

        stall_en = 1'b1;
        for (int k = 0; k < 8; k++) begin
            access(1'b0, 1'b0, rv_pkg::size_word, 12'h300 + 4 * k, lcg_next());
        end
        for (int k = 0; k < 40; k++) begin
            val = lcg_next();
            wa  = 12'h300 + 4 * (val[2:0]);
            case (val[4:3])
                2'd0:    access(val[5], val[6], rv_pkg::size_byte, wa + val[9:8], lcg_next());
                2'd1:    access(val[5], val[6], rv_pkg::size_half, wa + 2 * val[8], lcg_next());
                default: access(val[5], 1'b0, rv_pkg::size_word, wa, lcg_next());
            endcase
        end
        stall_en = 1'b0;
        wait_idle();
        end_test("5 response back-pressure");

        t0 = cycle;
        for (int k = 0; k < 16; k++) begin
            access(k[0], 1'b0, rv_pkg::size_word, 12'h300 + 4 * (k / 2), lcg_next());
        end
        if (cycle - t0 != 16) begin
            err_count++;
            $display("back-to-back requests were not accepted one per cycle");
        end
        wait_idle();
        end_test("6 back-to-back throughput");

        report_and_finish();
    end

endmodule

`default_nettype wire
